// File: logic/soc_pkg.sv
package soc_pkg;

  // bus word types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;
  typedef logic [1:0]  chip_sel_t;
  typedef logic [2:0]  irq_code_t;

  // chip select codes
  localparam chip_sel_t CS_NONE  = 2'd0;
  localparam chip_sel_t CS_RAM   = 2'd1;
  localparam chip_sel_t CS_TIMER = 2'd2;

  // memory map, top address nibble
  localparam logic [3:0] REGION_RAM   = 4'h0;
  localparam logic [3:0] REGION_TIMER = 4'h2;

  localparam int RAM_WORDS    = 64;
  localparam int RAM_ADR_BITS = 6;

  localparam int TIMER_COUNT = 4;

  // timer word offsets, adr[4:2]
  localparam logic [2:0] TMR_CTRL     = 3'd0;
  localparam logic [2:0] TMR_STATUS   = 3'd1;
  localparam logic [2:0] TMR_CMP_BASE = 3'd4;

  // cpu interrupt codes
  localparam irq_code_t IRQ_NONE    = 3'd0;
  localparam irq_code_t IRQ_FAULT   = 3'd1;
  localparam irq_code_t IRQ_TIMER0  = 3'd2;
  localparam irq_code_t IRQ_TIMER1  = 3'd3;
  localparam irq_code_t IRQ_TIMER2  = 3'd4;
  localparam irq_code_t IRQ_TIMER3  = 3'd5;
  localparam irq_code_t IRQ_UART_RX = 3'd6;
  localparam irq_code_t IRQ_UART_TX = 3'd7;

endpackage

// File: logic/soc_bus_if.sv
`timescale 1ns/1ps

// master request as seen by every slave
interface soc_bus_if;
  import soc_pkg::*;

  addr_t adr;
  data_t wdat;
  sel_t  sel;
  logic  we;
  logic  cyc;

  // interconnect side
  modport fabric (
    output adr,
    output wdat,
    output sel,
    output we,
    output cyc
  );

  // slave side
  modport slave (
    input adr,
    input wdat,
    input sel,
    input we,
    input cyc
  );

endinterface

// File: logic/bus_interconnect.sv
`timescale 1ns/1ps

module bus_interconnect (
  input  logic              sysclock,
  input  logic              rst_i,
  input  logic              cyc_i,
  input  logic              we_i,
  input  soc_pkg::addr_t    adr_i,
  input  soc_pkg::sel_t     sel_i,
  input  soc_pkg::data_t    dat_i,
  output soc_pkg::data_t    dat_o,
  output logic              ack_o,
  soc_bus_if.fabric         bus,
  output logic              ram_stb_o,
  input  soc_pkg::data_t    ram_rdat_i,
  input  logic              ram_ack_i,
  output logic              tmr_stb_o,
  input  soc_pkg::data_t    tmr_rdat_i,
  input  logic              tmr_ack_i,
  output logic              fault_o
);
  import soc_pkg::*;

  logic [3:0] region;
  chip_sel_t  cs;
  logic       fault;
  logic       fault_ack_q;

  assign region = adr_i[31:28];

  // region decode, only while a cycle is open
  always_comb begin
    cs    = CS_NONE;
    fault = 1'b0;
    if (cyc_i) begin
      case (region)
        REGION_RAM:   cs = CS_RAM;
        REGION_TIMER: cs = CS_TIMER;
        default:      fault = 1'b1;
      endcase
    end
  end

  // request fans out to all slaves
  assign bus.adr  = adr_i;
  assign bus.wdat = dat_i;
  assign bus.sel  = sel_i;
  assign bus.we   = we_i;
  assign bus.cyc  = cyc_i;

  assign ram_stb_o = (cs == CS_RAM);
  assign tmr_stb_o = (cs == CS_TIMER);

  // unmapped access gets its own ack so the master moves on
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      fault_ack_q <= 1'b0;
    end else if (!cyc_i) begin
      fault_ack_q <= 1'b0;
    end else begin
      fault_ack_q <= fault & ~fault_ack_q;
    end
  end

  // return path by chip select
  always_comb begin
    case (cs)
      CS_RAM: begin
        dat_o = ram_rdat_i;
        ack_o = ram_ack_i;
      end
      CS_TIMER: begin
        dat_o = tmr_rdat_i;
        ack_o = tmr_ack_i;
      end
      default: begin
        dat_o = '0;
        ack_o = fault_ack_q;
      end
    endcase
  end

  assign fault_o = fault;

endmodule

// File: logic/onchip_ram.sv
`timescale 1ns/1ps

module onchip_ram (
  input  logic           sysclock,
  input  logic           rst_i,
  soc_bus_if.slave       bus,
  input  logic           stb_i,
  output soc_pkg::data_t rdat_o,
  output logic           ack_o
);
  import soc_pkg::*;

  data_t                   mem [RAM_WORDS];
  data_t                   rdat_q;
  logic [RAM_ADR_BITS-1:0] word_idx;
  logic [1:0]              ack_q;
  logic                    active;
  logic                    commit;

  assign word_idx = bus.adr[RAM_ADR_BITS+1:2];
  assign active   = stb_i & bus.cyc;

  // stage 2 about to fire
  assign commit = active & ack_q[0];

  // two cycle ack, single pulse per access
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= 2'b00;
    end else if (!active) begin
      ack_q <= 2'b00;
    end else begin
      ack_q <= {ack_q[0], ~ack_q[0] & ~ack_q[1]};
    end
  end

  // byte lane writes, registered read
  always_ff @(posedge sysclock) begin
    if (commit && bus.we) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.sel[b]) begin
          mem[word_idx][8*b +: 8] <= bus.wdat[8*b +: 8];
        end
      end
    end
    rdat_q <= mem[word_idx];
  end

  assign rdat_o = rdat_q;
  assign ack_o  = ack_q[1];

endmodule

// File: logic/timer_unit.sv
`timescale 1ns/1ps

module timer_unit (
  input  logic                            sysclock,
  input  logic                            rst_i,
  soc_bus_if.slave                        bus,
  input  logic                            stb_i,
  output soc_pkg::data_t                  rdat_o,
  output logic                            ack_o,
  output logic [soc_pkg::TIMER_COUNT-1:0] irq_o
);
  import soc_pkg::*;

  logic [TIMER_COUNT-1:0] enable_q;
  logic [TIMER_COUNT-1:0] pending_q;
  logic [TIMER_COUNT-1:0] hit;
  logic [TIMER_COUNT-1:0] clear;
  data_t                  count_q [TIMER_COUNT];
  data_t                  cmp_q [TIMER_COUNT];
  logic                   ack_q;
  logic [2:0]             reg_ofs;
  logic                   wr_en;

  assign reg_ofs = bus.adr[4:2];

  // write lands on the acking edge
  assign wr_en = stb_i & bus.cyc & bus.we & ~ack_q;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i & bus.cyc & ~ack_q;
    end
  end

  assign ack_o = ack_q;

  // per channel compare match
  always_comb begin
    for (int i = 0; i < TIMER_COUNT; i++) begin
      hit[i] = enable_q[i] && (count_q[i] == cmp_q[i]);
    end
  end

  // write 1 to clear status bits
  always_comb begin
    clear = '0;
    if (wr_en && bus.sel[0] && reg_ofs == TMR_STATUS) begin
      clear = bus.wdat[TIMER_COUNT-1:0];
    end
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      enable_q  <= '0;
      pending_q <= '0;
      for (int i = 0; i < TIMER_COUNT; i++) begin
        count_q[i] <= '0;
      end
    end else begin
      if (wr_en && bus.sel[0] && reg_ofs == TMR_CTRL) begin
        enable_q <= bus.wdat[TIMER_COUNT-1:0];
      end
      // a new match wins over a clear in the same cycle
      pending_q <= (pending_q & ~clear) | hit;
      for (int i = 0; i < TIMER_COUNT; i++) begin
        if (hit[i]) begin
          count_q[i] <= '0;
        end else if (enable_q[i]) begin
          count_q[i] <= count_q[i] + 32'd1;
        end
      end
    end
  end

  // compare registers, byte lane writes
  always_ff @(posedge sysclock) begin
    if (wr_en && reg_ofs >= TMR_CMP_BASE) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.sel[b]) begin
          cmp_q[reg_ofs[1:0]][8*b +: 8] <= bus.wdat[8*b +: 8];
        end
      end
    end
  end

  // register readback
  always_comb begin
    rdat_o = '0;
    case (reg_ofs)
      TMR_CTRL:   rdat_o[TIMER_COUNT-1:0] = enable_q;
      TMR_STATUS: rdat_o[TIMER_COUNT-1:0] = pending_q;
      default: begin
        if (reg_ofs >= TMR_CMP_BASE) begin
          rdat_o = cmp_q[reg_ofs[1:0]];
        end
      end
    endcase
  end

  // level interrupts straight from the pending flags
  assign irq_o = pending_q;

endmodule

// File: logic/irq_encoder.sv
`timescale 1ns/1ps

module irq_encoder (
  input  logic                            int_en_i,
  input  logic                            fault_i,
  input  logic [soc_pkg::TIMER_COUNT-1:0] timer_irq_i,
  input  logic                            uart_rx_i,
  input  logic                            uart_tx_i,
  output soc_pkg::irq_code_t              irq_code_o
);
  import soc_pkg::*;

  // fault first, then timers high to low, then uart
  always_comb begin
    irq_code_o = IRQ_NONE;
    if (int_en_i) begin
      if (fault_i) begin
        irq_code_o = IRQ_FAULT;
      end else if (timer_irq_i[3]) begin
        irq_code_o = IRQ_TIMER3;
      end else if (timer_irq_i[2]) begin
        irq_code_o = IRQ_TIMER2;
      end else if (timer_irq_i[1]) begin
        irq_code_o = IRQ_TIMER1;
      end else if (timer_irq_i[0]) begin
        irq_code_o = IRQ_TIMER0;
      end else if (uart_rx_i) begin
        irq_code_o = IRQ_UART_RX;
      end else if (uart_tx_i) begin
        irq_code_o = IRQ_UART_TX;
      end
    end
  end

endmodule

// File: logic/soc_core.sv
`timescale 1ns/1ps

module soc_core (
  input  logic               sysclock,
  input  logic               rst_i,
  input  logic               cyc_i,
  input  logic               we_i,
  input  soc_pkg::addr_t     adr_i,
  input  soc_pkg::sel_t      sel_i,
  input  soc_pkg::data_t     dat_i,
  output soc_pkg::data_t     dat_o,
  output logic               ack_o,
  input  logic               int_en_i,
  input  logic               uart_rx_irq_i,
  input  logic               uart_tx_irq_i,
  output soc_pkg::irq_code_t cpu_irq_o,
  output logic               fault_o
);
  import soc_pkg::*;

  soc_bus_if bus ();

  logic                   ram_stb;
  logic                   ram_ack;
  data_t                  ram_rdat;
  logic                   tmr_stb;
  logic                   tmr_ack;
  data_t                  tmr_rdat;
  logic [TIMER_COUNT-1:0] timer_irq;
  logic                   fault;

  bus_interconnect u_interconnect (
    .sysclock   (sysclock),
    .rst_i      (rst_i),
    .cyc_i      (cyc_i),
    .we_i       (we_i),
    .adr_i      (adr_i),
    .sel_i      (sel_i),
    .dat_i      (dat_i),
    .dat_o      (dat_o),
    .ack_o      (ack_o),
    .bus        (bus.fabric),
    .ram_stb_o  (ram_stb),
    .ram_rdat_i (ram_rdat),
    .ram_ack_i  (ram_ack),
    .tmr_stb_o  (tmr_stb),
    .tmr_rdat_i (tmr_rdat),
    .tmr_ack_i  (tmr_ack),
    .fault_o    (fault)
  );

  onchip_ram u_ram (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .bus      (bus.slave),
    .stb_i    (ram_stb),
    .rdat_o   (ram_rdat),
    .ack_o    (ram_ack)
  );

  timer_unit u_timer (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .bus      (bus.slave),
    .stb_i    (tmr_stb),
    .rdat_o   (tmr_rdat),
    .ack_o    (tmr_ack),
    .irq_o    (timer_irq)
  );

  irq_encoder u_irq (
    .int_en_i    (int_en_i),
    .fault_i     (fault),
    .timer_irq_i (timer_irq),
    .uart_rx_i   (uart_rx_irq_i),
    .uart_tx_i   (uart_tx_irq_i),
    .irq_code_o  (cpu_irq_o)
  );

  assign fault_o = fault;

endmodule

// File: verification/soc_core_tb.sv
`timescale 1ns/1ps

module soc_core_tb;
  import soc_pkg::*;

  typedef enum logic [1:0] {
    OP_WR,
    OP_RD,
    OP_WAIT
  } op_t;

  // one bus transfer with its side inputs and expected response
  typedef struct packed {
    op_t       op;
    addr_t     adr;
    sel_t      sel;
    data_t     wdat;
    logic      rx;
    logic      tx;
    logic      en;
    data_t     exp_data;
    logic      exp_fault;
    irq_code_t exp_irq;
  } row_t;

  logic      sysclock;
  logic      rst_i;
  logic      cyc_i;
  logic      we_i;
  addr_t     adr_i;
  sel_t      sel_i;
  data_t     dat_i;
  data_t     dat_o;
  logic      ack_o;
  logic      int_en_i;
  logic      uart_rx_irq_i;
  logic      uart_tx_irq_i;
  irq_code_t cpu_irq_o;
  logic      fault_o;

  row_t        rows [$];
  data_t       ram_model [RAM_WORDS];
  int          cycle_count;
  int unsigned seed;

  soc_core UUT (
    .sysclock      (sysclock),
    .rst_i         (rst_i),
    .cyc_i         (cyc_i),
    .we_i          (we_i),
    .adr_i         (adr_i),
    .sel_i         (sel_i),
    .dat_i         (dat_i),
    .dat_o         (dat_o),
    .ack_o         (ack_o),
    .int_en_i      (int_en_i),
    .uart_rx_irq_i (uart_rx_irq_i),
    .uart_tx_irq_i (uart_tx_irq_i),
    .cpu_irq_o     (cpu_irq_o),
    .fault_o       (fault_o)
  );

  initial begin
    sysclock = 1'b0;
    forever #2 sysclock = ~sysclock;
  end

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_irq(input irq_code_t got, input irq_code_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // cycle limit scales with the table
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge sysclock);
      cycle_count++;
      if (cycle_count > rows.size() * 300 + 100) begin
        $display("Timeout: the bus did not finish the test table within %0d cycles",
                 rows.size() * 300 + 100);
        stop_with_failure();
      end
    end
  end

  function automatic addr_t ram_addr(input int idx);
    ram_addr = {REGION_RAM, 20'd0, idx[RAM_ADR_BITS-1:0], 2'b00};
  endfunction

  function automatic addr_t tmr_addr(input logic [2:0] ofs);
    tmr_addr = {REGION_TIMER, 23'd0, ofs, 2'b00};
  endfunction

  task automatic add_row(input op_t op, input addr_t adr, input sel_t sel, input data_t wdat,
                         input logic rx, input logic tx, input logic en,
                         input data_t exp_data, input irq_code_t exp_irq);
    row_t r;
    r.op        = op;
    r.adr       = adr;
    r.sel       = sel;
    r.wdat      = wdat;
    r.rx        = rx;
    r.tx        = tx;
    r.en        = en;
    r.exp_data  = exp_data;
    // only the two mapped regions are fault free
    r.exp_fault = (adr[31:28] != REGION_RAM) && (adr[31:28] != REGION_TIMER);
    r.exp_irq   = exp_irq;
    rows.push_back(r);
  endtask

  task automatic ram_write(input int idx, input sel_t sel, input data_t data);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        ram_model[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
    add_row(OP_WR, ram_addr(idx), sel, data, 1'b0, 1'b0, 1'b1, '0, IRQ_NONE);
  endtask

  task automatic ram_read(input int idx, input logic rx, input logic tx, input logic en,
                          input irq_code_t exp_irq);
    add_row(OP_RD, ram_addr(idx), 4'hF, '0, rx, tx, en, ram_model[idx], exp_irq);
  endtask

  task automatic build_table();
    // full words first, partial lanes merge onto them
    for (int i = 0; i < 8; i++) begin
      ram_write(i, 4'hF, $urandom());
    end
    ram_write(63, 4'hF, $urandom());
    ram_write(0, 4'b0001, $urandom());
    ram_write(1, 4'b0010, $urandom());
    ram_write(2, 4'b1100, $urandom());
    ram_write(3, 4'b0101, $urandom());
    ram_write(4, 4'b1000, $urandom());
    ram_write(5, 4'b0000, $urandom());
    ram_write(63, 4'b0110, $urandom());
    for (int i = 0; i < 6; i++) begin
      ram_read(i, 1'b0, 1'b0, 1'b1, IRQ_NONE);
    end
    ram_read(6, 1'b0, 1'b1, 1'b1, IRQ_UART_TX);
    ram_read(7, 1'b1, 1'b1, 1'b1, IRQ_UART_RX);
    ram_read(63, 1'b1, 1'b0, 1'b0, IRQ_NONE);

    // unmapped regions
    add_row(OP_RD, 32'h4000_0010, 4'hF, '0, 1'b0, 1'b0, 1'b1, '0, IRQ_FAULT);
    add_row(OP_RD, 32'hF000_0000, 4'hF, '0, 1'b1, 1'b1, 1'b1, '0, IRQ_FAULT);
    add_row(OP_RD, 32'h8000_0004, 4'hF, '0, 1'b0, 1'b0, 1'b0, '0, IRQ_NONE);
    add_row(OP_WR, 32'h1000_0000, 4'hF, $urandom(), 1'b0, 1'b0, 1'b1, '0, IRQ_FAULT);

    // single channel, poll then clear
    add_row(OP_WR, tmr_addr(TMR_CMP_BASE), 4'hF, 32'd20, 1'b0, 1'b0, 1'b1, '0, IRQ_NONE);
    add_row(OP_WR, tmr_addr(TMR_CTRL), 4'hF, 32'h1, 1'b0, 1'b0, 1'b1, '0, IRQ_NONE);
    add_row(OP_WAIT, tmr_addr(TMR_STATUS), 4'hF, 32'h1, 1'b0, 1'b0, 1'b1, 32'h1, IRQ_TIMER0);
    add_row(OP_WR, tmr_addr(TMR_CTRL), 4'hF, 32'h0, 1'b0, 1'b0, 1'b1, '0, IRQ_TIMER0);
    add_row(OP_WR, tmr_addr(TMR_STATUS), 4'hF, 32'h1, 1'b0, 1'b0, 1'b1, '0, IRQ_NONE);
    add_row(OP_RD, tmr_addr(TMR_STATUS), 4'hF, '0, 1'b0, 1'b0, 1'b1, 32'h0, IRQ_NONE);

    // three channels, well spread compare values
    add_row(OP_WR, tmr_addr(3'd5), 4'hF, 32'd10, 1'b0, 1'b0, 1'b1, '0, IRQ_NONE);
    add_row(OP_WR, tmr_addr(3'd6), 4'hF, 32'd30, 1'b0, 1'b0, 1'b1, '0, IRQ_NONE);
    add_row(OP_WR, tmr_addr(3'd7), 4'hF, 32'd50, 1'b0, 1'b0, 1'b1, '0, IRQ_NONE);
    add_row(OP_RD, tmr_addr(3'd5), 4'hF, '0, 1'b0, 1'b0, 1'b1, 32'd10, IRQ_NONE);
    add_row(OP_WR, tmr_addr(TMR_CTRL), 4'hF, 32'hE, 1'b0, 1'b0, 1'b1, '0, IRQ_NONE);
    add_row(OP_WAIT, tmr_addr(TMR_STATUS), 4'hF, 32'h2, 1'b0, 1'b0, 1'b1, 32'h2, IRQ_TIMER1);
    add_row(OP_WAIT, tmr_addr(TMR_STATUS), 4'hF, 32'h4, 1'b1, 1'b0, 1'b1, 32'h6, IRQ_TIMER2);
    add_row(OP_WAIT, tmr_addr(TMR_STATUS), 4'hF, 32'h8, 1'b0, 1'b1, 1'b1, 32'hE, IRQ_TIMER3);
    add_row(OP_RD, tmr_addr(TMR_STATUS), 4'hF, '0, 1'b1, 1'b1, 1'b1, 32'hE, IRQ_TIMER3);
    add_row(OP_RD, tmr_addr(TMR_STATUS), 4'hF, '0, 1'b1, 1'b1, 1'b0, 32'hE, IRQ_NONE);
    add_row(OP_RD, 32'h3000_0000, 4'hF, '0, 1'b1, 1'b1, 1'b1, '0, IRQ_FAULT);
    add_row(OP_WR, tmr_addr(TMR_CTRL), 4'hF, 32'h0, 1'b1, 1'b1, 1'b1, '0, IRQ_TIMER3);
    add_row(OP_WR, tmr_addr(TMR_STATUS), 4'hF, 32'h8, 1'b1, 1'b1, 1'b1, '0, IRQ_TIMER2);
    add_row(OP_WR, tmr_addr(TMR_STATUS), 4'hF, 32'h4, 1'b1, 1'b1, 1'b1, '0, IRQ_TIMER1);
    add_row(OP_WR, tmr_addr(TMR_STATUS), 4'hF, 32'h2, 1'b1, 1'b1, 1'b1, '0, IRQ_UART_RX);
    add_row(OP_RD, tmr_addr(TMR_STATUS), 4'hF, '0, 1'b0, 1'b1, 1'b1, 32'h0, IRQ_UART_TX);
    add_row(OP_RD, tmr_addr(TMR_STATUS), 4'hF, '0, 1'b0, 1'b0, 1'b1, 32'h0, IRQ_NONE);
  endtask

  // one cycle-qualified transfer, response sampled mid cycle
  task automatic bus_transfer(input logic we, input addr_t adr, input sel_t sel,
                              input data_t wdat, input logic rx, input logic tx,
                              input logic en, output data_t rdat, output irq_code_t code,
                              output logic flt);
    @(posedge sysclock);
    cyc_i         <= 1'b1;
    we_i          <= we;
    adr_i         <= adr;
    sel_i         <= sel;
    dat_i         <= wdat;
    uart_rx_irq_i <= rx;
    uart_tx_irq_i <= tx;
    int_en_i      <= en;
    @(negedge sysclock);
    while (ack_o !== 1'b1) begin
      @(negedge sysclock);
    end
    rdat = dat_o;
    code = cpu_irq_o;
    flt  = fault_o;
    @(posedge sysclock);
    cyc_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic apply_row(input int idx);
    row_t      r;
    data_t     rdat;
    irq_code_t code;
    logic      flt;
    string     tag;
    r    = rows[idx];
    tag  = $sformatf("row %0d", idx);
    rdat = '0;
    if (r.op == OP_WAIT) begin
      // poll status until the awaited pending bit shows up
      while ((rdat & r.wdat) == '0) begin
        bus_transfer(1'b0, r.adr, r.sel, '0, r.rx, r.tx, r.en, rdat, code, flt);
      end
    end else begin
      bus_transfer(r.op == OP_WR, r.adr, r.sel, r.wdat, r.rx, r.tx, r.en, rdat, code, flt);
    end
    if (r.op != OP_WR) begin
      check_data(rdat, r.exp_data, {tag, " read data"});
    end
    check_irq(code, r.exp_irq, {tag, " interrupt code"});
    check_bit(flt, r.exp_fault, {tag, " fault flag"});
  endtask

  initial begin
    seed = 99694;
    void'($urandom(seed));
    rst_i         = 1'b1;
    cyc_i         = 1'b0;
    we_i          = 1'b0;
    adr_i         = '0;
    sel_i         = '0;
    dat_i         = '0;
    // enabled so the reset check sees the pending flags and fault
    int_en_i      = 1'b1;
    uart_rx_irq_i = 1'b0;
    uart_tx_irq_i = 1'b0;
    build_table();
    repeat (4) @(posedge sysclock);
    rst_i <= 1'b0;
    @(negedge sysclock);
    check_bit(ack_o, 1'b0, "ack after reset");
    check_bit(fault_o, 1'b0, "fault after reset");
    check_irq(cpu_irq_o, IRQ_NONE, "interrupt code after reset");
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(i);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: files.f
logic/soc_pkg.sv
logic/soc_bus_if.sv
logic/bus_interconnect.sv
logic/onchip_ram.sv
logic/timer_unit.sv
logic/irq_encoder.sv
logic/soc_core.sv
verification/soc_core_tb.sv
